// ==== list.f ====
verilog/mc_pkg.sv
verilog/mc_tile_router.sv
verilog/mc_vcache_bank.sv
verilog/mc_host_bridge.sv
verilog/mc_pod.sv
tb/tb_clock.sv
tb/tb_mc_pod.sv

// ==== run.sh ====
#!/bin/sh
# build the pod testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/100ps --top-module tb_mc_pod \
    -f list.f -o tb_mc_pod &&
  ./obj_dir/tb_mc_pod | tee /dev/stderr | grep -q "TESTS PASSED" ||
  { echo "simulation did not pass"; exit 1; }

// ==== tb/tb_mc_pod.sv ====
// testbench for the manycore pod
// directed Wishbone accesses to every vcache bank through the host bridge
`default_nettype none

module tb_mc_pod
  import mc_pkg::*;
  ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_x_lp    = 4;
  localparam int words_lp    = 16;
  localparam int banks_lp    = 2 * num_x_lp;
  localparam int ack_wait_lp = 100;
  // reads, write/read per bank twice, one bank filled and overwritten, gap test
  localparam int accesses_lp = banks_lp + 4 * banks_lp + 2 * words_lp + 1 + 6;
  localparam int watchdog_lp = 200 * accesses_lp + 40;

  logic                 clk;
  logic                 arst_n;
  logic                 wb_cyc, wb_stb, wb_we;
  logic [mc_data_w-1:0] wb_adr, wb_dat, wb_dat_o;
  logic                 wb_ack_o;
  logic [31:0]          lcg_state = 32'hdedc43e2;
  string                test_name;
  int                   errors, test_errors, checks, tests_run;

  tb_clock #(.period_p(100)) clock_gen (.clk_o(clk));

  mc_pod mc_pod_i (
    .clk_i(clk)
    ,.arst_n_i(arst_n)
    ,.wb_cyc_i(wb_cyc)
    ,.wb_stb_i(wb_stb)
    ,.wb_we_i(wb_we)
    ,.wb_adr_i(wb_adr)
    ,.wb_dat_i(wb_dat)
    ,.wb_dat_o(wb_dat_o)
    ,.wb_ack_o(wb_ack_o)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // adr[3:0] word, adr[4] side, column above
  function automatic logic [mc_data_w-1:0] bank_addr(input int col, input int side,
                                                     input int word);
    return (32'(col) << 5) | (32'(side) << 4) | 32'(word);
  endfunction

  task automatic compare_word(input string name, input logic [mc_data_w-1:0] exp_v,
                              input logic [mc_data_w-1:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (exp_v !== act_v) begin
      $display("ERROR %s: expected %b, actual %b", name, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s done, %0d errors", test_name, test_errors);
  endtask

  // one classic cycle, held until ack, then dropped
  task automatic wb_access(input logic we, input logic [mc_data_w-1:0] adr,
                           input logic [mc_data_w-1:0] wdata,
                           output logic [mc_data_w-1:0] rdata);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    @(posedge clk);
    #5;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdata;
    while (!got && n < ack_wait_lp) begin
      @(negedge clk);
      got = wb_ack_o;
      n++;
    end
    rdata = wb_dat_o;
    if (!got) begin
      if (we) begin
        $display("%s: no ack for write to address %h", test_name, adr);
      end else begin
        $display("%s: no ack for read from address %h", test_name, adr);
      end
      errors++;
      test_errors++;
    end
    @(posedge clk);
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    // ack lasts one cycle only
    if (got) begin
      compare_bit({test_name, " ack width"}, 1'b0, wb_ack_o);
    end
  endtask

  task automatic write_word(input int col, input int side, input int word,
                            input logic [mc_data_w-1:0] data);
    logic [mc_data_w-1:0] unused_rd;
    wb_access(1'b1, bank_addr(col, side, word), data, unused_rd);
  endtask

  task automatic check_word(input int col, input int side, input int word,
                            input logic [mc_data_w-1:0] exp_v);
    logic [mc_data_w-1:0] rd;
    wb_access(1'b0, bank_addr(col, side, word), '0, rd);
    compare_word(test_name, exp_v, rd);
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      compare_bit(test_name, 1'b0, wb_ack_o);
    end
    @(posedge clk);
    #5;
    arst_n = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      compare_bit(test_name, 1'b0, wb_ack_o);
    end
    end_test();
  endtask

  task automatic test_read_before_write();
    int w;
    start_test("read_before_write");
    for (int b = 0; b < banks_lp; b++) begin
      w = lcg_next() % words_lp;
      check_word(b / 2, b % 2, w, '0);
    end
    end_test();
  endtask

  task automatic test_every_bank();
    int                   w;
    logic [mc_data_w-1:0] val;
    start_test("write_read_every_bank");
    for (int col = 0; col < num_x_lp; col++) begin
      for (int side = 0; side < 2; side++) begin
        w   = lcg_next() % words_lp;
        val = lcg_next();
        write_word(col, side, w, val);
        check_word(col, side, w, val);
      end
    end
    end_test();
  endtask

  task automatic test_bank_isolation();
    logic [mc_data_w-1:0] vals [banks_lp];
    start_test("bank_isolation");
    // consecutive LCG values never repeat, so every bank gets its own value
    for (int b = 0; b < banks_lp; b++) begin
      vals[b] = lcg_next();
      write_word(b / 2, b % 2, 5, vals[b]);
    end
    for (int b = 0; b < banks_lp; b++) begin
      check_word(b / 2, b % 2, 5, vals[b]);
    end
    end_test();
  endtask

  task automatic test_word_overwrite();
    logic [mc_data_w-1:0] vals [words_lp];
    start_test("word_isolation_overwrite");
    for (int w = 0; w < words_lp; w++) begin
      vals[w] = lcg_next();
      write_word(2, 1, w, vals[w]);
    end
    vals[7] = ~vals[7];
    write_word(2, 1, 7, vals[7]);
    for (int w = 0; w < words_lp; w++) begin
      check_word(2, 1, w, vals[w]);
    end
    end_test();
  endtask

  task automatic test_ack_protocol();
    logic [mc_data_w-1:0] val;
    start_test("ack_protocol");
    for (int i = 0; i < 3; i++) begin
      val = lcg_next();
      write_word(i, i % 2, i + 3, val);
      // idle gap with cyc low
      for (int g = 0; g < i + 2; g++) begin
        @(negedge clk);
        compare_bit(test_name, 1'b0, wb_ack_o);
      end
      check_word(i, i % 2, i + 3, val);
    end
    end_test();
  endtask

  initial begin
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat      = '0;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    tests_run   = 0;
    test_reset_state();
    test_read_before_write();
    test_every_bank();
    test_bank_isolation();
    test_word_overwrite();
    test_ack_protocol();
    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (watchdog_lp) @(posedge clk);
    $display("watchdog expired after %0d cycles in test %s", watchdog_lp, test_name);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// testbench clock source, free running from time zero
`default_nettype none

module tb_clock #(parameter int period_p = 100) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk_o = 1'b0;
  always #(period_p / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verilog/mc_pod.sv ====
// manycore pod top level
// north vcache row, tile mesh, south vcache row and the host bridge,
// with the local links and the reset release chain
`default_nettype none

module mc_pod
  import mc_pkg::*;
  #(parameter int num_tiles_x_p = 4
    , parameter int num_tiles_y_p = 2
    , parameter int bank_words_p = 16
  )
  (
    input  wire logic                   clk_i
    , input  wire logic                 arst_n_i
    , input  wire logic                 wb_cyc_i
    , input  wire logic                 wb_stb_i
    , input  wire logic                 wb_we_i
    , input  wire logic [mc_data_w-1:0] wb_adr_i
    , input  wire logic [mc_data_w-1:0] wb_dat_i
    , output logic [mc_data_w-1:0]      wb_dat_o
    , output logic                      wb_ack_o
  );

  localparam int last_y_lp = num_tiles_y_p - 1;
  localparam int last_x_lp = num_tiles_x_p - 1;

  mc_link_s [num_tiles_x_p-1:0] north_req, north_resp;
  mc_link_s [num_tiles_x_p-1:0] south_req, south_resp;
  logic     [num_tiles_x_p-1:0] north_rst_lo, south_rst_lo;

  mc_link_s [num_tiles_y_p-1:0][num_tiles_x_p-1:0][dir_s:dir_w] tile_li, tile_lo;
  logic     [num_tiles_y_p-1:0][num_tiles_x_p-1:0]              tile_rst_lo;

  mc_link_s bridge_link_lo, bridge_link_li;

  for (genvar x = 0; x < num_tiles_x_p; x++) begin : north_vc_x
    mc_vcache_bank #(.bank_words_p(bank_words_p)) north_vc (
      .clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.rst_chain_i(arst_n_i)
      ,.rst_chain_o(north_rst_lo[x])
      ,.req_i(north_req[x])
      ,.resp_o(north_resp[x])
    );
    assign north_req[x] = tile_lo[0][x][dir_n];
  end

  for (genvar y = 0; y < num_tiles_y_p; y++) begin : mc_y
    for (genvar x = 0; x < num_tiles_x_p; x++) begin : mc_x
      mc_tile_router #(.tile_x_p(x), .tile_y_p(y + 1)) tile (
        .clk_i(clk_i)
        ,.arst_n_i(arst_n_i)
        ,.rst_chain_i(y == 0 ? north_rst_lo[x] : tile_rst_lo[(y == 0) ? 0 : y-1][x])
        ,.rst_chain_o(tile_rst_lo[y][x])
        ,.link_i(tile_li[y][x])
        ,.link_o(tile_lo[y][x])
      );

      // west, host attaches on the first tile row only
      if (x == 0) begin
        assign tile_li[y][x][dir_w] = (y == 0) ? bridge_link_lo : '0;
      end else begin
        assign tile_li[y][x][dir_w] = tile_lo[y][x-1][dir_e];
      end

      if (x == last_x_lp) begin
        assign tile_li[y][x][dir_e] = '0;
      end else begin
        assign tile_li[y][x][dir_e] = tile_lo[y][x+1][dir_w];
      end

      if (y == 0) begin
        assign tile_li[y][x][dir_n] = north_resp[x];
      end else begin
        assign tile_li[y][x][dir_n] = tile_lo[y-1][x][dir_s];
      end

      if (y == last_y_lp) begin
        assign tile_li[y][x][dir_s] = south_resp[x];
      end else begin
        assign tile_li[y][x][dir_s] = tile_lo[y+1][x][dir_n];
      end
    end
  end

  for (genvar x = 0; x < num_tiles_x_p; x++) begin : south_vc_x
    mc_vcache_bank #(.bank_words_p(bank_words_p)) south_vc (
      .clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.rst_chain_i(tile_rst_lo[last_y_lp][x])
      ,.rst_chain_o(south_rst_lo[x])
      ,.req_i(south_req[x])
      ,.resp_o(south_resp[x])
    );
    assign south_req[x] = tile_lo[last_y_lp][x][dir_s];
  end

  assign bridge_link_li = tile_lo[0][0][dir_w];

  // bridge waits for the end of the chain
  mc_host_bridge #(.num_tiles_y_p(num_tiles_y_p), .num_tiles_x_p(num_tiles_x_p)) host (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.rst_chain_i(south_rst_lo[last_x_lp])
    ,.wb_cyc_i(wb_cyc_i)
    ,.wb_stb_i(wb_stb_i)
    ,.wb_we_i(wb_we_i)
    ,.wb_adr_i(wb_adr_i)
    ,.wb_dat_i(wb_dat_i)
    ,.wb_dat_o(wb_dat_o)
    ,.wb_ack_o(wb_ack_o)
    ,.link_o(bridge_link_lo)
    ,.link_i(bridge_link_li)
  );

endmodule

`default_nettype wire

// ==== verilog/mc_host_bridge.sv ====
// host bridge
// Wishbone classic slave, one request packet in flight at a time,
// acks when the response comes back
`default_nettype none

module mc_host_bridge
  import mc_pkg::*;
  #(parameter int num_tiles_y_p = 2
    , parameter int num_tiles_x_p = 4
  )
  (
    input  wire logic                   clk_i
    , input  wire logic                 arst_n_i
    , input  wire logic                 rst_chain_i
    , input  wire logic                 wb_cyc_i
    , input  wire logic                 wb_stb_i
    , input  wire logic                 wb_we_i
    , input  wire logic [mc_data_w-1:0] wb_adr_i
    , input  wire logic [mc_data_w-1:0] wb_dat_i
    , output logic [mc_data_w-1:0]      wb_dat_o
    , output logic                      wb_ack_o
    , output mc_link_s                  link_o
    , input  wire mc_link_s             link_i
  );

  typedef enum logic {
    st_idle,
    st_wait
  } state_e;

  localparam logic [mc_data_w-6:0] cols_lp = (mc_data_w-5)'(num_tiles_x_p);

  state_e               state_q;
  logic                 accept;
  logic [mc_data_w-6:0] col;
  mc_packet_s           req_pkt;

  // ack cycle blocks the same cycle from being taken twice
  assign accept = (state_q == st_idle) && rst_chain_i && wb_cyc_i && wb_stb_i && !wb_ack_o;

  // adr[3:0] word, adr[4] side, adr[31:5] column
  assign col            = wb_adr_i[mc_data_w-1:5] % cols_lp;
  assign req_pkt.op     = wb_we_i ? op_store : op_load;
  assign req_pkt.dest_x = mc_x_cord_w'(col);
  assign req_pkt.dest_y = wb_adr_i[4] ? mc_y_cord_w'(num_tiles_y_p + 1) : '0;
  assign req_pkt.addr   = mc_addr_w'(wb_adr_i[3:0]);
  assign req_pkt.data   = wb_dat_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= st_idle;
      link_o   <= '0;
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      link_o.v <= 1'b0;
      wb_ack_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            link_o.v   <= 1'b1;
            link_o.pkt <= req_pkt;
            state_q    <= st_wait;
          end
        end
        st_wait: begin
          if (link_i.v) begin
            wb_dat_o <= link_i.pkt.data;
            wb_ack_o <= 1'b1;
            state_q  <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mc_vcache_bank.sv ====
// vcache bank at a pod edge
// word memory serving loads and stores, answers toward the host
`default_nettype none

module mc_vcache_bank
  import mc_pkg::*;
  #(parameter int bank_words_p = 16)
  (
    input  wire logic       clk_i
    , input  wire logic     arst_n_i
    , input  wire logic     rst_chain_i
    , output logic          rst_chain_o
    , input  wire mc_link_s req_i
    , output mc_link_s      resp_o
  );

  localparam int idx_w_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;

  logic [mc_data_w-1:0] mem_q [bank_words_p];
  logic [idx_w_lp-1:0]  idx;
  logic                 is_store;

  assign idx      = req_i.pkt.addr[idx_w_lp-1:0];
  assign is_store = req_i.v && (req_i.pkt.op == op_store);

  // cleared while the chain holds this bank in reset
  always_ff @(posedge clk_i) begin
    if (!rst_chain_i) begin
      for (int i = 0; i < bank_words_p; i++) begin
        mem_q[i] <= '0;
      end
    end else if (is_store) begin
      mem_q[idx] <= req_i.pkt.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_chain_o <= 1'b0;
      resp_o      <= '0;
    end else begin
      rst_chain_o <= rst_chain_i;
      resp_o.v    <= rst_chain_i && req_i.v;
      if (req_i.v) begin
        resp_o.pkt.op     <= op_resp;
        resp_o.pkt.dest_x <= '0;
        resp_o.pkt.dest_y <= mc_y_cord_w'(mc_host_y);
        resp_o.pkt.addr   <= req_i.pkt.addr;
        // store data is echoed back
        resp_o.pkt.data   <= is_store ? req_i.pkt.data : mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mc_tile_router.sv ====
// mesh tile router
// registers one packet per cycle toward its X then Y output
// and stages the reset release chain
`default_nettype none

module mc_tile_router
  import mc_pkg::*;
  #(parameter int tile_x_p = 0
    , parameter int tile_y_p = 1
  )
  (
    input  wire logic                   clk_i
    , input  wire logic                 arst_n_i
    , input  wire logic                 rst_chain_i
    , output logic                      rst_chain_o
    , input  wire mc_link_s [dir_s:dir_w] link_i
    , output mc_link_s [dir_s:dir_w]    link_o
  );

  localparam logic [mc_x_cord_w-1:0] my_x_lp = mc_x_cord_w'(tile_x_p);
  localparam logic [mc_y_cord_w-1:0] my_y_lp = mc_y_cord_w'(tile_y_p);

  mc_link_s               in_sel;
  mc_dir_e                out_dir;
  mc_link_s [dir_s:dir_w] link_n;

  // only one packet lives in the network, so at most one input is valid
  always_comb begin
    in_sel = '0;
    for (int d = 0; d < 4; d++) begin
      if (link_i[d].v) begin
        in_sel = link_i[d];
      end
    end
  end

  // dimension ordered, X first
  always_comb begin
    if (in_sel.pkt.dest_x > my_x_lp) begin
      out_dir = dir_e;
    end else if (in_sel.pkt.dest_x < my_x_lp) begin
      out_dir = dir_w;
    end else if (in_sel.pkt.dest_y < my_y_lp) begin
      out_dir = dir_n;
    end else if (in_sel.pkt.dest_y > my_y_lp) begin
      out_dir = dir_s;
    end else begin
      // arrived at the host row, bridge sits to the west
      out_dir = dir_w;
    end
  end

  always_comb begin
    for (int d = 0; d < 4; d++) begin
      link_n[d]     = link_o[d];
      link_n[d].v   = 1'b0;
    end
    if (in_sel.v) begin
      link_n[out_dir] = in_sel;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_chain_o <= 1'b0;
    end else begin
      rst_chain_o <= rst_chain_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      link_o <= '0;
    end else if (!rst_chain_i) begin
      for (int d = 0; d < 4; d++) begin
        link_o[d].v <= 1'b0;
      end
    end else begin
      link_o <= link_n;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mc_pkg.sv ====
// manycore pod shared definitions
// coordinate widths, packet kinds, packet and link structs
`default_nettype none

package mc_pkg;

  localparam int mc_data_w   = 32;
  localparam int mc_x_cord_w = 3;
  localparam int mc_y_cord_w = 3;
  localparam int mc_addr_w   = 8;

  // row of the host attachment, dest y of every response
  localparam int mc_host_y = 1;

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_resp  = 2'd2
  } mc_op_e;

  typedef struct packed {
    mc_op_e                 op;
    logic [mc_x_cord_w-1:0] dest_x;
    logic [mc_y_cord_w-1:0] dest_y;
    logic [mc_addr_w-1:0]   addr;
    logic [mc_data_w-1:0]   data;
  } mc_packet_s;

  // one direction of one link, no ready
  typedef struct packed {
    logic       v;
    mc_packet_s pkt;
  } mc_link_s;

  typedef enum logic [1:0] {
    dir_w = 2'd0,
    dir_e = 2'd1,
    dir_n = 2'd2,
    dir_s = 2'd3
  } mc_dir_e;

endpackage

`default_nettype wire
